// ==== common/aes_pkg.sv ====
// ####################
// AES round types, cipher op enum
// GF(2^8) doubling and quadrupling
// ####################
`default_nettype none

package aes_pkg;

  // One state byte
  typedef logic [7:0] byte_t;
  // One column, byte 0 in bits 7:0
  typedef logic [31:0] column_t;
  // Four columns, column c in bits 32c+31:32c
  typedef logic [127:0] state_t;

  // Direction of the round
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic byte_t aes_mul2(input byte_t in);
    byte_t out;
    out = {in[6:0], 1'b0};
    // Reduce when the top bit falls out
    if (in[7]) begin
      out = out ^ 8'h1b;
    end
    return out;
  endfunction

  // Multiply by x^2, two doublings
  function automatic byte_t aes_mul4(input byte_t in);
    byte_t tmp;
    tmp = aes_mul2(in);
    return aes_mul2(tmp);
  endfunction

endpackage

`default_nettype wire

// ==== common/aes_apb_pkg.sv ====
// ####################
// APB word type, register map
// ####################
`default_nettype none

package aes_apb_pkg;

  // APB data word
  typedef logic [31:0] apb_word_t;

  // Byte offsets, only the low 6 address bits decode
  parameter logic [5:0] STATE_BASE  = 6'h00;
  parameter logic [5:0] KEY_BASE    = 6'h10;
  parameter logic [5:0] CTRL_OFS    = 6'h20;
  parameter logic [5:0] STATUS_OFS  = 6'h24;
  parameter logic [5:0] RESULT_BASE = 6'h30;

  // CTRL fields
  parameter int CTRL_START_BIT = 0;
  parameter int CTRL_INV_BIT   = 1;
  parameter int CTRL_FINAL_BIT = 2;

  // STATUS fields
  parameter int STATUS_BUSY_BIT = 0;
  parameter int STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

// ==== common/aes_state_if.sv ====
// ####################
// Launched state bundle
// ####################
`default_nettype none

interface aes_state_if;

  import aes_pkg::*;

  // One-cycle pulse, no back-pressure
  logic     valid;
  ciph_op_e op;
  logic     final_rnd;
  state_t   state;

  // Producer side
  modport src (output valid, output op, output final_rnd, output state);

  // Consumer side
  modport dst (input valid, input op, input final_rnd, input state);

endinterface

`default_nettype wire

// ==== aes_mix/aes_mix_single_column.sv ====
// ####################
// Fwd/inv MixColumns, one column
// ####################
`default_nettype none

module aes_mix_single_column (
  input  aes_pkg::ciph_op_e op_i,
  input  aes_pkg::column_t  data_i,
  output aes_pkg::column_t  data_o
);

  import aes_pkg::*;

  byte_t [3:0] d;
  byte_t [3:0] x;
  byte_t [3:0] x_mul2;
  byte_t [1:0] y_pre;
  byte_t [1:0] y;
  byte_t       y2;
  byte_t [1:0] z;
  byte_t [1:0] z_sel;
  byte_t [3:0] out;

  assign d = data_i;

  // Neighbour sums shared by all four rows
  assign x[0] = d[0] ^ d[3];
  assign x[1] = d[3] ^ d[2];
  assign x[2] = d[2] ^ d[1];
  assign x[3] = d[1] ^ d[0];

  for (genvar i = 0; i < 4; i++) begin : gen_x_mul2
    assign x_mul2[i] = aes_mul2(x[i]);
  end

  // Opposite-byte sums, quadrupled
  assign y_pre[0] = d[3] ^ d[1];
  assign y_pre[1] = d[2] ^ d[0];

  for (genvar i = 0; i < 2; i++) begin : gen_y_mul4
    assign y[i] = aes_mul4(y_pre[i]);
  end

  assign y2 = aes_mul2(y[0] ^ y[1]);

  // Inverse correction terms
  assign z[0] = y2 ^ y[0];
  assign z[1] = y2 ^ y[1];

  // Forward needs no correction
  assign z_sel[0] = (op_i == CIPH_INV) ? z[0] : 8'h00;
  assign z_sel[1] = (op_i == CIPH_INV) ? z[1] : 8'h00;

  // 2a0 + 3a1 + a2 + a3 and rotations, plus correction
  assign out[0] = d[1] ^ x_mul2[3] ^ x[1] ^ z_sel[1];
  assign out[1] = d[0] ^ x_mul2[2] ^ x[1] ^ z_sel[0];
  assign out[2] = d[3] ^ x_mul2[1] ^ x[3] ^ z_sel[1];
  assign out[3] = d[2] ^ x_mul2[0] ^ x[3] ^ z_sel[0];

  assign data_o = out;

endmodule

`default_nettype wire

// ==== aes_mix/aes_mix_columns.sv ====
// ####################
// State path: (Inv)ShiftRows, optional
// (Inv)MixColumns, output register
// ####################
`default_nettype none

module aes_mix_columns (
  input  logic            clk_i,
  input  logic            reset_i,
  aes_state_if.dst        launch,
  aes_state_if.src        mixed
);

  import aes_pkg::*;

  state_t shifted;
  state_t mix_out;
  state_t next_state;

  // Row r rotates left by r going forward, right by r going back
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        if (launch.op == CIPH_FWD) begin
          shifted[32*c+8*r +: 8] = launch.state[32*((c+r)%4)+8*r +: 8];
        end else begin
          shifted[32*c+8*r +: 8] = launch.state[32*((c+4-r)%4)+8*r +: 8];
        end
      end
    end
  end

  // One mixer per column
  for (genvar c = 0; c < 4; c++) begin : gen_col
    aes_mix_single_column u_mix (
      .op_i   (launch.op),
      .data_i (shifted[32*c +: 32]),
      .data_o (mix_out[32*c +: 32])
    );
  end

  // Final round skips the mix
  assign next_state = launch.final_rnd ? shifted : mix_out;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mixed.valid     <= 1'b0;
      mixed.op        <= CIPH_FWD;
      mixed.final_rnd <= 1'b0;
      mixed.state     <= '0;
    end else begin
      mixed.valid <= launch.valid;
      // Hold data between launches
      if (launch.valid) begin
        mixed.op        <= launch.op;
        mixed.final_rnd <= launch.final_rnd;
        mixed.state     <= next_state;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/aes_key_stage.sv ====
// ####################
// Key path, round key register
// ####################
`default_nettype none

module aes_key_stage (
  input  logic           clk_i,
  input  logic           reset_i,
  aes_state_if.dst       launch,
  input  aes_pkg::state_t key_i,
  output aes_pkg::state_t round_key_o
);

  import aes_pkg::*;

  state_t key_imc;
  logic   use_imc;

  // InvMixColumns of the raw key
  for (genvar c = 0; c < 4; c++) begin : gen_col
    aes_mix_single_column u_imc (
      .op_i   (CIPH_INV),
      .data_i (key_i[32*c +: 32]),
      .data_o (key_imc[32*c +: 32])
    );
  end

  // Equivalent inverse cipher, only for full inverse rounds
  assign use_imc = (launch.op == CIPH_INV) && !launch.final_rnd;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      round_key_o <= '0;
    end else if (launch.valid) begin
      // Same latency as the state path
      round_key_o <= use_imc ? key_imc : key_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/aes_add_round_key.sv ====
// ####################
// Combiner, XOR and output register
// ####################
`default_nettype none

module aes_add_round_key (
  input  logic            clk_i,
  input  logic            reset_i,
  aes_state_if.dst        mixed,
  input  aes_pkg::state_t round_key_i,
  aes_state_if.src        result
);

  import aes_pkg::*;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result.valid     <= 1'b0;
      result.op        <= CIPH_FWD;
      result.final_rnd <= 1'b0;
      result.state     <= '0;
    end else begin
      // mixed.valid also marks the key
      result.valid <= mixed.valid;
      if (mixed.valid) begin
        result.op        <= mixed.op;
        result.final_rnd <= mixed.final_rnd;
        result.state     <= mixed.state ^ round_key_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/aes_apb_regs.sv ====
// ####################
// APB register file, start FSM
// busy/done status, result capture
// ####################
`default_nettype none

module aes_apb_regs #(
  parameter int APB_ADDR_W = 12
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [APB_ADDR_W-1:0] paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  aes_apb_pkg::apb_word_t pwdata_i,
  output aes_apb_pkg::apb_word_t prdata_o,
  output logic                  pslverr_o,
  aes_state_if.src              launch,
  output aes_pkg::state_t       launch_key_o,
  aes_state_if.dst              result
);

  import aes_pkg::*;
  import aes_apb_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } fsm_e;

  fsm_e   fsm_q;
  logic   done_q;
  logic   busy;
  state_t state_q;
  state_t key_q;
  state_t result_q;
  logic   ctrl_inv_q;
  logic   ctrl_final_q;

  logic [5:0] addr_lo;
  logic       addr_hi;
  logic [1:0] word_idx;
  logic       hit_state;
  logic       hit_key;
  logic       hit_ctrl;
  logic       hit_status;
  logic       hit_result;
  logic       mapped;
  logic       access;
  logic       wr;
  logic       start_req;
  logic       start_ok;
  logic       start_busy;
  logic       wr_ro;

  // Decode, upper address bits must be clear
  assign addr_lo    = paddr_i[5:0];
  assign addr_hi    = |paddr_i[APB_ADDR_W-1:6];
  assign word_idx   = addr_lo[3:2];
  assign hit_state  = !addr_hi && (addr_lo[5:4] == STATE_BASE[5:4]);
  assign hit_key    = !addr_hi && (addr_lo[5:4] == KEY_BASE[5:4]);
  assign hit_ctrl   = !addr_hi && (addr_lo[5:2] == CTRL_OFS[5:2]);
  assign hit_status = !addr_hi && (addr_lo[5:2] == STATUS_OFS[5:2]);
  assign hit_result = !addr_hi && (addr_lo[5:4] == RESULT_BASE[5:4]);
  assign mapped     = hit_state | hit_key | hit_ctrl | hit_status | hit_result;

  // Access phase, completes this edge
  assign access = psel_i & penable_i;
  assign wr     = access & pwrite_i;

  assign busy       = (fsm_q == BUSY);
  assign start_req  = wr & hit_ctrl & pwdata_i[CTRL_START_BIT];
  assign start_ok   = start_req & !busy;
  assign start_busy = start_req & busy;
  // STATUS and RESULT are read-only
  assign wr_ro      = pwrite_i & (hit_status | hit_result);

  assign pslverr_o = access & (!mapped | wr_ro | start_busy);

  // Read mux
  always_comb begin
    prdata_o = '0;
    if (hit_state) begin
      prdata_o = state_q[32*word_idx +: 32];
    end else if (hit_key) begin
      prdata_o = key_q[32*word_idx +: 32];
    end else if (hit_ctrl) begin
      prdata_o[CTRL_INV_BIT]   = ctrl_inv_q;
      prdata_o[CTRL_FINAL_BIT] = ctrl_final_q;
    end else if (hit_status) begin
      prdata_o[STATUS_BUSY_BIT] = busy;
      prdata_o[STATUS_DONE_BIT] = done_q;
    end else if (hit_result) begin
      prdata_o = result_q[32*word_idx +: 32];
    end
  end

  // Data registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= '0;
      key_q        <= '0;
      ctrl_inv_q   <= 1'b0;
      ctrl_final_q <= 1'b0;
    end else begin
      if (wr && hit_state) begin
        state_q[32*word_idx +: 32] <= pwdata_i;
      end
      if (wr && hit_key) begin
        key_q[32*word_idx +: 32] <= pwdata_i;
      end
      // Rejected START leaves the mode bits alone
      if (wr && hit_ctrl && !start_busy) begin
        ctrl_inv_q   <= pwdata_i[CTRL_INV_BIT];
        ctrl_final_q <= pwdata_i[CTRL_FINAL_BIT];
      end
    end
  end

  // Start FSM, done flag, result capture
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fsm_q        <= IDLE;
      done_q       <= 1'b0;
      launch.valid <= 1'b0;
      result_q     <= '0;
    end else begin
      launch.valid <= start_ok;
      case (fsm_q)
        IDLE: begin
          if (start_ok) begin
            fsm_q  <= BUSY;
            done_q <= 1'b0;
          end
        end
        BUSY: begin
          // Three edges after START
          if (result.valid) begin
            fsm_q    <= IDLE;
            done_q   <= 1'b1;
            result_q <= result.state;
          end
        end
        default: fsm_q <= IDLE;
      endcase
    end
  end

  // Launch payload straight from the registers, stable while valid
  assign launch.op        = ctrl_inv_q ? CIPH_INV : CIPH_FWD;
  assign launch.final_rnd = ctrl_final_q;
  assign launch.state     = state_q;
  assign launch_key_o     = key_q;

endmodule

`default_nettype wire

// ==== verilog/aes_round_apb.sv ====
// ####################
// AES round accelerator top, APB
// ####################
`default_nettype none

module aes_round_apb #(
  parameter int APB_ADDR_W = 12
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [APB_ADDR_W-1:0]  paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  aes_apb_pkg::apb_word_t pwdata_i,
  output aes_apb_pkg::apb_word_t prdata_o,
  output logic                   pslverr_o
);

  import aes_pkg::*;

  // Register file to both paths
  aes_state_if launch_if ();
  // State path to combiner
  aes_state_if mixed_if ();
  // Combiner back to register file
  aes_state_if result_if ();

  state_t launch_key;
  state_t round_key;

  aes_apb_regs #(
    .APB_ADDR_W (APB_ADDR_W)
  ) u_regs (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pslverr_o    (pslverr_o),
    .launch       (launch_if.src),
    .launch_key_o (launch_key),
    .result       (result_if.dst)
  );

  aes_mix_columns u_mix_columns (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .launch  (launch_if.dst),
    .mixed   (mixed_if.src)
  );

  aes_key_stage u_key_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .launch      (launch_if.dst),
    .key_i       (launch_key),
    .round_key_o (round_key)
  );

  aes_add_round_key u_add_round_key (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mixed       (mixed_if.dst),
    .round_key_i (round_key),
    .result      (result_if.src)
  );

endmodule

`default_nettype wire

// ==== dv/aes_round_chk.sv ====
// ####################
// APB and status assertions, bound into the top
// ####################
`default_nettype none

module aes_round_chk (
  input logic clk_i,
  input logic reset_i,
  input logic psel_i,
  input logic penable_i,
  input logic pslverr_o,
  input logic busy_i,
  input logic done_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Access phase always preceded by setup
  penable_after_psel: assert property (@(posedge clk_i) disable iff (reset_i)
    penable_i |-> $past(psel_i))
    else $error("penable_i without psel_i in the previous cycle");

  // Status flags are exclusive
  busy_done_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(busy_i && done_i))
    else $error("busy and done set together");

  // Error only in the access phase
  slverr_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
    pslverr_o |-> (psel_i && penable_i))
    else $error("pslverr_o outside an access phase");

endmodule

bind aes_round_apb aes_round_chk u_chk (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pslverr_o (pslverr_o),
  .busy_i    (u_regs.busy),
  .done_i    (u_regs.done_q)
);

`default_nettype wire

// ==== dv/aes_round_tb.sv ====
// ####################
// AES round testbench, APB driver
// case file reader, checks, report
// ####################
`default_nettype none

module aes_round_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import aes_pkg::*;
  import aes_apb_pkg::*;

  localparam int ADDR_W = 12;

  logic              clk_i;
  logic              reset_i;
  logic [ADDR_W-1:0] paddr_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  apb_word_t         pwdata_i;
  apb_word_t         prdata_o;
  logic              pslverr_o;

  // Cases as read from the file
  logic   op_q[$];
  logic   fin_q[$];
  state_t st_q[$];
  state_t key_q[$];
  state_t exp_q[$];

  int errors;
  int tests;
  int limit_cycles;

  aes_round_apb #(
    .APB_ADDR_W (ADDR_W)
  ) DUT (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o)
  );

  always #10 clk_i = ~clk_i;

  // File lists byte 0 first, DUT holds byte 0 in bits 7:0
  function automatic state_t fips_order(input state_t in);
    state_t out;
    for (int i = 0; i < 16; i++) begin
      out[8*i +: 8] = in[8*(15-i) +: 8];
    end
    return out;
  endfunction

  // Byte 4c+r takes byte of column c+r, same row
  function automatic state_t shift_rows(input state_t in);
    state_t out;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        out[8*(4*c+r) +: 8] = in[8*(4*((c+r)%4)+r) +: 8];
      end
    end
    return out;
  endfunction

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic idle_gap();
    repeat ($urandom % 2) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic wr,
                            input apb_word_t data, output apb_word_t rd, output logic err);
    paddr_i  = addr;
    pwrite_i = wr;
    pwdata_i = data;
    psel_i   = 1'b1;
    @(posedge clk_i);
    #2 penable_i = 1'b1;
    // Mid access phase, outputs settled
    @(negedge clk_i);
    rd  = prdata_o;
    err = pslverr_o;
    @(posedge clk_i);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic load_and_start(input logic op, input logic fin, input state_t s, input state_t k);
    apb_word_t rd;
    apb_word_t ctrl;
    logic      err;
    for (int w = 0; w < 4; w++) begin
      apb_access({6'd0, STATE_BASE} + 4*w, 1'b1, s[32*w +: 32], rd, err);
      check_val("pslverr_o", err, 0);
      idle_gap();
      apb_access({6'd0, KEY_BASE} + 4*w, 1'b1, k[32*w +: 32], rd, err);
      check_val("pslverr_o", err, 0);
      idle_gap();
    end
    ctrl = '0;
    ctrl[CTRL_START_BIT] = 1'b1;
    ctrl[CTRL_INV_BIT]   = op;
    ctrl[CTRL_FINAL_BIT] = fin;
    apb_access({6'd0, CTRL_OFS}, 1'b1, ctrl, rd, err);
    check_val("pslverr_o", err, 0);
  endtask

  task automatic wait_done(output state_t res);
    apb_word_t rd;
    logic      err;
    int        polls;
    polls = 0;
    rd    = '0;
    while (!rd[STATUS_DONE_BIT] && polls < 20) begin
      apb_access({6'd0, STATUS_OFS}, 1'b0, '0, rd, err);
      polls++;
    end
    if (!rd[STATUS_DONE_BIT]) begin
      $display("done never set after 20 STATUS reads");
      errors++;
    end
    for (int w = 0; w < 4; w++) begin
      apb_access({6'd0, RESULT_BASE} + 4*w, 1'b0, '0, rd, err);
      res[32*w +: 32] = rd;
      idle_gap();
    end
  endtask

  // Full round with a STATUS read straight after START
  task automatic run_round(input logic op, input logic fin, input state_t s, input state_t k,
                           output state_t res);
    apb_word_t rd;
    logic      err;
    load_and_start(op, fin, s, k);
    apb_access({6'd0, STATUS_OFS}, 1'b0, '0, rd, err);
    check_val("STATUS", rd, 32'h1);
    wait_done(res);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    end
  endtask

  // Watchdog, sized once the case count is known
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Run stopped, timed out after %0d cycles", limit_cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int        fd;
    int        n_fwd;
    int        e0;
    int        op;
    int        fin;
    string     line;
    state_t    s;
    state_t    k;
    state_t    x;
    state_t    res;
    state_t    back;
    apb_word_t rd;
    logic      err;
    void'($urandom(32'h8d76));
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    errors    = 0;
    tests     = 0;
    n_fwd     = 0;
    limit_cycles = 0;
    fd = $fopen("dv/aes_round_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file");
      $display("Simulation failed");
      $finish;
    end else begin
      while ($fgets(line, fd)) begin
        // Comment and blank lines do not match
        if ($sscanf(line, "%d %d %h %h %h", op, fin, s, k, x) == 5) begin
          op_q.push_back(op[0]);
          fin_q.push_back(fin[0]);
          st_q.push_back(fips_order(s));
          key_q.push_back(fips_order(k));
          exp_q.push_back(fips_order(x));
          n_fwd += (op == 0 && fin == 0) ? 1 : 0;
        end
      end
      $fclose(fd);
      // Round trips add two runs per forward round, plus status and error tests
      limit_cycles = (op_q.size() + 2 * n_fwd + 2 + 4) * 40;
      repeat (2) @(posedge clk_i);
      #2 reset_i = 1'b0;
      for (int i = 0; i < op_q.size(); i++) begin
        e0 = errors;
        run_round(op_q[i], fin_q[i], st_q[i], key_q[i], res);
        check_val("RESULT", res, exp_q[i]);
        // Inverse full round then inverse final round undo a forward round
        if (op_q[i] == 1'b0 && fin_q[i] == 1'b0) begin
          run_round(1'b1, 1'b0, shift_rows(res), key_q[i], back);
          check_val("RESULT", back, shift_rows(st_q[i]));
          run_round(1'b1, 1'b1, back, '0, back);
          check_val("RESULT", back, st_q[i]);
        end
        report_test($sformatf("case %0d", i), e0);
      end
      // STATE and KEY readback
      e0 = errors;
      load_and_start(1'b0, 1'b0, st_q[0], key_q[0]);
      for (int w = 0; w < 4; w++) begin
        apb_access({6'd0, STATE_BASE} + 4*w, 1'b0, '0, rd, err);
        check_val("STATE", rd, st_q[0][32*w +: 32]);
        apb_access({6'd0, KEY_BASE} + 4*w, 1'b0, '0, rd, err);
        check_val("KEY", rd, key_q[0][32*w +: 32]);
      end
      wait_done(res);
      check_val("RESULT", res, exp_q[0]);
      report_test("readback", e0);
      // Error responses
      e0 = errors;
      load_and_start(op_q[1], fin_q[1], st_q[1], key_q[1]);
      // Rejected START asks for another mode, a relaunch would change RESULT
      apb_access({6'd0, CTRL_OFS}, 1'b1, 32'h7, rd, err);
      check_val("pslverr_o", err, 1);
      wait_done(res);
      check_val("RESULT", res, exp_q[1]);
      apb_access(12'h028, 1'b0, '0, rd, err);
      check_val("pslverr_o", err, 1);
      apb_access(12'h100, 1'b0, '0, rd, err);
      check_val("pslverr_o", err, 1);
      apb_access({6'd0, RESULT_BASE}, 1'b1, 32'hffff_ffff, rd, err);
      check_val("pslverr_o", err, 1);
      report_test("errors", e0);
      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== aes_round_apb.f ====
common/aes_pkg.sv
common/aes_apb_pkg.sv
common/aes_state_if.sv
aes_mix/aes_mix_single_column.sv
aes_mix/aes_mix_columns.sv
verilog/aes_key_stage.sv
verilog/aes_add_round_key.sv
verilog/aes_apb_regs.sv
verilog/aes_round_apb.sv
dv/aes_round_chk.sv
dv/aes_round_tb.sv

// ==== dv/aes_round_cases.txt ====
# op (0 fwd, 1 inv), final flag, state, key, expected result
# 128-bit values as 16 bytes in FIPS-197 order, byte 0 first
0 0 d42711aee0bf98f1b8b45de51e415230 a0fafe1788542cb123a339392a6c7605 a49c7ff2689f352b6b5bea43026a5049
0 0 49ded28945db96f17f39871a7702533b f2c295f27a96b9435935807a7359f67f aa8f5f0361dde3ef82d24ad26832469a
0 0 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000
0 1 d42711aee0bf98f1b8b45de51e415230 a0fafe1788542cb123a339392a6c7605 7445a32768e07e1f9be228c8344beee0
0 1 49ded28945db96f17f39871a7702533b 00000000000000000000000000000000 49db873b453953897f02d2f177de961a
1 0 a49fea49685b50f26b6a7f2b029c3543 a0fafe1788542cb123a339392a6c7605 d4bf5d30e0b452aeb84111f11e2798e5
1 0 aadd4a9a61d2460382325fef688fe3d2 f2c295f27a96b9435935807a7359f67f 49db873b453953897f02d2f177de961a
1 1 a49fea49685b50f26b6a7f2b029c3543 a0fafe1788542cb123a339392a6c7605 046681e5e0cb199a48f8d37a2806264c
1 1 04cbd34ce0f826e54806819a2866197a 00000000000000000000000000000000 046681e5e0cb199a48f8d37a2806264c
